/* source/mem_pkg.sv */
package mem_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int DATA_W = 32;
    localparam int LANE_W = 8;
    localparam int LANES  = 4;
    localparam int ADDR_W = 10;

    // Row address inside one byte bank
    localparam int ROW_W  = ADDR_W - 2;

    //////////////////////////////////////////////////////////////////////
    // Access size codes
    //////////////////////////////////////////////////////////////////////

    localparam logic [1:0] SIZE_BYTE  = 2'd0;
    localparam logic [1:0] SIZE_HALF  = 2'd1;
    localparam logic [1:0] SIZE_THREE = 2'd2;
    localparam logic [1:0] SIZE_WORD  = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // Data word views
    //////////////////////////////////////////////////////////////////////

    // Byte lanes for rotation, halfwords for halfword extension
    typedef union packed {
        logic [LANES-1:0][LANE_W-1:0] lane;
        logic [1:0][DATA_W/2-1:0]     half;
    } mem_word_u;

endpackage

/* source/lsu_request.sv */
module lsu_request (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          req,
    input  logic                                          we,
    input  logic [1:0]                                    size,
    input  logic                                          sign,
    input  logic [mem_pkg::ADDR_W-1:0]                    addr,
    input  logic [mem_pkg::DATA_W-1:0]                    wdata,
    output logic [mem_pkg::LANES-1:0][mem_pkg::ROW_W-1:0] bank_row,
    output logic [mem_pkg::LANES-1:0]                     bank_we,
    output logic [mem_pkg::DATA_W-1:0]                    bank_wdata,
    output logic                                          ld_valid,
    output logic [1:0]                                    ld_size,
    output logic                                          ld_sign,
    output logic [1:0]                                    ld_shift
);
    import mem_pkg::*;

    logic [1:0]                  lane_off;
    logic [ROW_W-1:0]            base_row;
    logic [2:0]                  byte_cnt;
    logic [LANES-1:0]            be_lin;
    logic [LANES-1:0]            be_rot;
    mem_word_u                   wdata_u;
    mem_word_u                   wdata_rot;
    logic [LANES-1:0][ROW_W-1:0] row_next;

    //////////////////////////////////////////////////////////////////////
    // Request decode
    //////////////////////////////////////////////////////////////////////

    assign lane_off = addr[1:0];
    assign base_row = addr[ADDR_W-1:2];
    assign wdata_u  = wdata;

    // Size code 0..3 maps to 1..4 bytes
    assign byte_cnt = {1'b0, size} + 3'd1;

    // Enables before rotation, lowest bytes first
    always_comb begin : lin_enables
        for (int i = 0; i < LANES; i++) begin
            be_lin[i] = (3'(i) < byte_cnt);
        end
    end

    // Bank k takes byte (k - offset) of the access
    always_comb begin : lane_rotate
        logic [1:0] src;
        src = '0;
        for (int k = 0; k < LANES; k++) begin
            src               = 2'(k) - lane_off;
            be_rot[k]         = be_lin[src];
            wdata_rot.lane[k] = wdata_u.lane[src];
            // Lanes below the offset belong to the next row, wrapping at the top
            row_next[k]       = base_row + ROW_W'(2'(k) < lane_off);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_we  <= '0;
            ld_valid <= 1'b0;
        end else begin
            bank_we  <= (req && we) ? be_rot : '0;
            ld_valid <= req && !we;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            bank_row   <= row_next;
            bank_wdata <= wdata_rot;
            ld_size    <= size;
            ld_sign    <= sign;
            ld_shift   <= lane_off;
        end
    end

endmodule

/* source/byte_bank_ram.sv */
module byte_bank_ram (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [mem_pkg::LANES-1:0][mem_pkg::ROW_W-1:0] bank_row,
    input  logic [mem_pkg::LANES-1:0]                     bank_we,
    input  logic [mem_pkg::DATA_W-1:0]                    bank_wdata,
    input  logic                                          ld_valid,
    input  logic [1:0]                                    ld_size,
    input  logic                                          ld_sign,
    input  logic [1:0]                                    ld_shift,
    output logic [mem_pkg::DATA_W-1:0]                    bank_rdata,
    output logic                                          ext_valid,
    output logic [1:0]                                    ext_size,
    output logic                                          ext_sign,
    output logic [1:0]                                    ext_shift
);
    import mem_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Byte banks
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < LANES; k++) begin : g_bank
        logic [LANE_W-1:0] mem [0:2**ROW_W-1];
        logic [LANE_W-1:0] rd_q;

        // Read first, so a same-row write shows up on the next read
        always_ff @(posedge clk) begin
            if (bank_we[k]) begin
                mem[bank_row[k]] <= bank_wdata[k*LANE_W +: LANE_W];
            end
            rd_q <= mem[bank_row[k]];
        end

        assign bank_rdata[k*LANE_W +: LANE_W] = rd_q;
    end

    //////////////////////////////////////////////////////////////////////
    // Load control delay, aligned with bank_rdata
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ext_valid <= 1'b0;
        end else begin
            ext_valid <= ld_valid;
        end
    end

    always_ff @(posedge clk) begin
        ext_size  <= ld_size;
        ext_sign  <= ld_sign;
        ext_shift <= ld_shift;
    end

endmodule

/* source/load_extend.sv */
module load_extend (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [mem_pkg::DATA_W-1:0] bank_rdata,
    input  logic                       ext_valid,
    input  logic [1:0]                 ext_size,
    input  logic                       ext_sign,
    input  logic [1:0]                 ext_shift,
    output logic [mem_pkg::DATA_W-1:0] rdata,
    output logic                       rvalid
);
    import mem_pkg::*;

    mem_word_u         bank_u;
    mem_word_u         algn_u;
    logic [DATA_W-1:0] keep_mask;
    logic              sign_bit;
    logic [DATA_W-1:0] ext_word;

    assign bank_u = bank_rdata;

    //////////////////////////////////////////////////////////////////////
    // Undo the lane rotation
    //////////////////////////////////////////////////////////////////////

    // Byte at the request address ends up in lane 0
    always_comb begin : lane_unrotate
        logic [1:0] src;
        src = '0;
        for (int k = 0; k < LANES; k++) begin
            src            = 2'(k) + ext_shift;
            algn_u.lane[k] = bank_u.lane[src];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sign or zero extension
    //////////////////////////////////////////////////////////////////////

    always_comb begin : size_select
        case (ext_size)
            SIZE_BYTE: begin
                sign_bit  = algn_u.lane[0][LANE_W-1];
                keep_mask = DATA_W'({LANE_W{1'b1}});
            end
            SIZE_HALF: begin
                sign_bit  = algn_u.half[0][DATA_W/2-1];
                keep_mask = DATA_W'({(2*LANE_W){1'b1}});
            end
            SIZE_THREE: begin
                sign_bit  = algn_u.lane[2][LANE_W-1];
                keep_mask = DATA_W'({(3*LANE_W){1'b1}});
            end
            SIZE_WORD: begin
                // Nothing above a full word to fill
                sign_bit  = 1'b0;
                keep_mask = '1;
            end
        endcase
    end

    assign ext_word = (algn_u & keep_mask) | ({DATA_W{ext_sign & sign_bit}} & ~keep_mask);

    // Result register, rdata holds between pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            rdata  <= '0;
        end else begin
            rvalid <= ext_valid;
            if (ext_valid) begin
                rdata <= ext_word;
            end
        end
    end

endmodule

/* source/data_mem_top.sv */
module data_mem_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    input  logic                       we,
    input  logic [1:0]                 size,
    input  logic                       sign,
    input  logic [mem_pkg::ADDR_W-1:0] addr,
    input  logic [mem_pkg::DATA_W-1:0] wdata,
    output logic [mem_pkg::DATA_W-1:0] rdata,
    output logic                       rvalid
);
    import mem_pkg::*;

    // Request stage to RAM
    logic [LANES-1:0][ROW_W-1:0] bank_row;
    logic [LANES-1:0]            bank_we;
    logic [DATA_W-1:0]           bank_wdata;
    logic                        ld_valid;
    logic [1:0]                  ld_size;
    logic                        ld_sign;
    logic [1:0]                  ld_shift;

    // RAM to load stage
    logic [DATA_W-1:0]           bank_rdata;
    logic                        ext_valid;
    logic [1:0]                  ext_size;
    logic                        ext_sign;
    logic [1:0]                  ext_shift;

    //////////////////////////////////////////////////////////////////////
    // Pipeline stages
    //////////////////////////////////////////////////////////////////////

    lsu_request i_request (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .we         (we),
        .size       (size),
        .sign       (sign),
        .addr       (addr),
        .wdata      (wdata),
        .bank_row   (bank_row),
        .bank_we    (bank_we),
        .bank_wdata (bank_wdata),
        .ld_valid   (ld_valid),
        .ld_size    (ld_size),
        .ld_sign    (ld_sign),
        .ld_shift   (ld_shift)
    );

    byte_bank_ram i_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .bank_row   (bank_row),
        .bank_we    (bank_we),
        .bank_wdata (bank_wdata),
        .ld_valid   (ld_valid),
        .ld_size    (ld_size),
        .ld_sign    (ld_sign),
        .ld_shift   (ld_shift),
        .bank_rdata (bank_rdata),
        .ext_valid  (ext_valid),
        .ext_size   (ext_size),
        .ext_sign   (ext_sign),
        .ext_shift  (ext_shift)
    );

    load_extend i_extend (
        .clk        (clk),
        .rst_n      (rst_n),
        .bank_rdata (bank_rdata),
        .ext_valid  (ext_valid),
        .ext_size   (ext_size),
        .ext_sign   (ext_sign),
        .ext_shift  (ext_shift),
        .rdata      (rdata),
        .rvalid     (rvalid)
    );

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 8;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* testbench/data_mem_sva.sv */
module data_mem_sva (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       req,
    input logic                       we,
    input logic [1:0]                 size,
    input logic                       sign,
    input logic [mem_pkg::ADDR_W-1:0] addr,
    input logic [mem_pkg::DATA_W-1:0] wdata,
    input logic [mem_pkg::DATA_W-1:0] rdata,
    input logic                       rvalid
);
    timeunit 1ns;
    timeprecision 1ps;
    import mem_pkg::*;

    logic [LANE_W-1:0] shadow [0:2**ADDR_W-1];
    logic [DATA_W-1:0] exp_pipe [0:2];
    int unsigned       fail_cnt = 0;

    // Little-endian gather, then fill above the accessed bytes
    function automatic logic [DATA_W-1:0] load_value(
        input logic [ADDR_W-1:0] a,
        input logic [1:0]        sz,
        input logic              sg
    );
        logic [DATA_W-1:0] v;
        int                nbits;
        v     = '0;
        nbits = (int'(sz) + 1) * LANE_W;
        for (int i = 0; i <= int'(sz); i++) begin
            v[i*LANE_W +: LANE_W] = shadow[ADDR_W'(int'(a) + i)];
        end
        for (int j = nbits; j < DATA_W; j++) begin
            v[j] = sg & v[nbits-1];
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Shadow memory and expected load results
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_n && req && we) begin
            for (int i = 0; i <= int'(size); i++) begin
                shadow[ADDR_W'(int'(addr) + i)] <= wdata[i*LANE_W +: LANE_W];
            end
        end
        exp_pipe[0] <= load_value(addr, size, sign);
        exp_pipe[1] <= exp_pipe[0];
        exp_pipe[2] <= exp_pipe[1];
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Result registered at the second edge after sampling, seen at the third
    a_load_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        req && !we |-> ##3 rvalid)
    else begin
        fail_cnt++;
        $error("rvalid did not follow a load request two cycles after sampling");
    end

    a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
        req && !we |-> ##3 rdata == exp_pipe[2])
    else begin
        fail_cnt++;
        $error("Error at %0t: rdata %h, expected %h", $time, $sampled(rdata),
               $sampled(exp_pipe[2]));
    end

    a_store_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        req && we |-> ##3 !rvalid)
    else begin
        fail_cnt++;
        $error("rvalid was raised after a store request");
    end

    a_reset_idle: assert property (@(posedge clk)
        !rst_n && $past(!rst_n) |-> !rvalid && rdata == '0)
    else begin
        fail_cnt++;
        $error("rvalid or rdata not cleared while in reset");
    end

endmodule

bind data_mem_top data_mem_sva i_sva (.*);

/* testbench/tb_data_mem.sv */
module tb_data_mem;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_pkg::*;

    localparam logic [31:0] SEED      = 32'h24ab30d3;
    localparam int          RESET_CYC = 8;
    localparam int          DRAIN_CYC = 4;
    localparam int          FILL_REQS = 2**ADDR_W / LANES;
    localparam int          WORD_REQS = 16 * 3;
    localparam int          PART_REQS = 8 * 5;
    localparam int          EXT_REQS  = 3 * 2 * 3;
    localparam int          WRAP_REQS = 4 * 4 * 2 * 2;
    localparam int          RAND_REQS = 400;
    localparam int          LIMIT_CYC = 2 * (RESET_CYC + FILL_REQS + WORD_REQS + PART_REQS
                                        + EXT_REQS + WRAP_REQS + RAND_REQS
                                        + 6 * (DRAIN_CYC + 1));

    logic              clk;
    logic              rst_n;
    logic              req;
    logic              we;
    logic [1:0]        size;
    logic              sign;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              rvalid;
    logic [31:0]       lfsr = SEED;
    int                cycle_cnt = 0;
    int unsigned       errs_seen = 0;
    int                tests_run = 0;
    int                tests_failed = 0;

    tb_clock_gen i_clk (.clk(clk), .rst_n(rst_n));

    data_mem_top i_dut (.*);

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // Each initial byte is a function of its full address
    function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] b);
        return b[7:0] ^ {4{b[9:8]}} ^ 8'h5a;
    endfunction

    task automatic send_req(input logic w, input logic [1:0] sz, input logic sg,
                            input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        @(posedge clk);
        req   <= 1'b1;
        we    <= w;
        size  <= sz;
        sign  <= sg;
        addr  <= a;
        wdata <= d;
    endtask

    // A few idle cycles empty the fixed-latency pipeline
    task automatic drain_pipe();
        @(posedge clk);
        req <= 1'b0;
        repeat (DRAIN_CYC) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        int unsigned errs;
        drain_pipe();
        errs      = i_dut.i_sva.fail_cnt - errs_seen;
        errs_seen = i_dut.i_sva.fail_cnt;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("Test %-26s %s, %0d assertion failures", name,
                 (errs == 0) ? "passed" : "FAILED", errs);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT_CYC) begin
            $display("Timed out after %0d cycles, the tests did not finish", cycle_cnt);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]       r;
        logic [31:0]       d;
        logic [ADDR_W-1:0] a;
        req   = 1'b0;
        we    = 1'b0;
        size  = SIZE_BYTE;
        sign  = 1'b0;
        addr  = '0;
        wdata = '0;
        wait (rst_n === 1'b1);

        // Every byte gets a known value before any load
        for (int row = 0; row < FILL_REQS; row++) begin
            a = ADDR_W'(row * LANES);
            send_req(1'b1, SIZE_WORD, 1'b0, a,
                     {fill_byte(ADDR_W'(a + 3)), fill_byte(ADDR_W'(a + 2)),
                      fill_byte(ADDR_W'(a + 1)), fill_byte(a)});
        end

        for (int i = 0; i < 16; i++) begin
            rand_bits(32, d);
            send_req(1'b1, SIZE_WORD, 1'b0, ADDR_W'(i * 64), d);
            send_req(1'b0, SIZE_WORD, 1'b0, ADDR_W'(i * 64), '0);
            send_req(1'b0, SIZE_WORD, 1'b1, ADDR_W'(i * 64), '0);
        end
        finish_test("word store and load");

        // Bytes 1 to 3 replaced by three different sizes and byte 0 kept
        for (int i = 0; i < 8; i++) begin
            a = ADDR_W'(i * 124 + 4);
            rand_bits(32, d);
            send_req(1'b1, SIZE_WORD, 1'b0, a, d);
            rand_bits(32, d);
            send_req(1'b1, SIZE_THREE, 1'b0, ADDR_W'(a + 1), d);
            rand_bits(32, d);
            send_req(1'b1, SIZE_HALF, 1'b0, ADDR_W'(a + 2), d);
            rand_bits(32, d);
            send_req(1'b1, SIZE_BYTE, 1'b0, ADDR_W'(a + 3), d);
            rand_bits(1, r);
            send_req(1'b0, SIZE_WORD, r[0], a, '0);
        end
        finish_test("partial stores");

        for (int sz = 0; sz < 3; sz++) begin
            for (int top = 0; top < 2; top++) begin
                rand_bits(ADDR_W, r);
                a = r[ADDR_W-1:0];
                rand_bits(32, d);
                d[(sz + 1) * 8 - 1] = top[0];
                send_req(1'b1, 2'(sz), 1'b0, a, d);
                send_req(1'b0, 2'(sz), 1'b0, a, '0);
                send_req(1'b0, 2'(sz), 1'b1, a, '0);
            end
        end
        finish_test("extension");

        // Bases at 1020 wrap to address 0 for the wider sizes
        for (int sz = 0; sz < 4; sz++) begin
            for (int off = 0; off < 4; off++) begin
                for (int b = 0; b < 2; b++) begin
                    a = ADDR_W'((b == 0 ? 1020 : 512) + off);
                    rand_bits(32, d);
                    rand_bits(1, r);
                    send_req(1'b1, 2'(sz), 1'b0, a, d);
                    send_req(1'b0, 2'(sz), r[0], a, '0);
                end
            end
        end
        finish_test("unaligned access and wrap");

        a = '0;
        for (int n = 0; n < RAND_REQS; n++) begin
            rand_bits(1, r);
            // Half the requests reuse the last address
            if (r[0] == 1'b0) begin
                rand_bits(ADDR_W, r);
                a = r[ADDR_W-1:0];
            end
            rand_bits(4, r);
            rand_bits(32, d);
            send_req(r[3], r[2:1], r[0], a, d);
        end
        finish_test("back-to-back random traffic");

        $display("Tests run: %0d, failed: %0d, assertion failures: %0d",
                 tests_run, tests_failed, errs_seen);
        if (tests_failed == 0 && errs_seen == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* list.f */
source/mem_pkg.sv
source/lsu_request.sv
source/byte_bank_ram.sv
source/load_extend.sv
source/data_mem_top.sv
testbench/tb_clock_gen.sv
testbench/data_mem_sva.sv
testbench/tb_data_mem.sv

/* Bender.yml */
package:
  name: data_mem

sources:
  - files:
      - source/mem_pkg.sv
      - source/lsu_request.sv
      - source/byte_bank_ram.sv
      - source/load_extend.sv
      - source/data_mem_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/data_mem_sva.sv
      - testbench/tb_data_mem.sv
